// File: bench/execute_assert.sv
`timescale 1ns/1ns
`default_nettype none

module execute_checker
    import exec_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      stall_i,
    input  exec_req_t req_i,
    input  logic      killed_o,
    input  logic      jump_o,
    input  word_t     jump_target_o,
    input  mem_req_t  mem_o,
    input  word_t     result_o,
    input  logic      write_enable_o,
    input  exec_op_e  op_o
);

    tag_t        model_tag;
    word_t       a;
    word_t       b;
    word_t       c;
    word_t       sum;
    word_t       exp_res;
    word_t       exp_target;
    word_t       exp_data;
    byte_en_t    exp_be;
    logic        live;
    logic        exp_cond;
    logic        is_load;
    logic        is_store;
    logic        is_branch;
    logic        has_res;
    int unsigned fail_count = 0;

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    always_comb begin
        a          = req_i.first_operand;
        b          = req_i.second_operand;
        c          = req_i.third_operand;
        sum        = a + b;
        live       = (req_i.tag == model_tag);
        is_load    = req_i.op inside {LB, LBU, LH, LHU, LW};
        is_store   = req_i.op inside {SB, SH, SW};
        is_branch  = req_i.op inside {BEQ, BNE, BLT, BLTU, BGE, BGEU};
        has_res    = !(is_branch || req_i.op == NOP);
        exp_res    = sum;
        exp_cond   = 1'b0;
        exp_target = req_i.pc + c;
        exp_be     = 4'b0000;
        exp_data   = c;
        case (req_i.op)
            SUB:  exp_res = a - b;
            AND:  exp_res = a & b;
            OR:   exp_res = a | b;
            XOR:  exp_res = a ^ b;
            SLL:  exp_res = a << b[4:0];
            SRL:  exp_res = a >> b[4:0];
            SRA:  exp_res = word_t'($signed(a) >>> b[4:0]);
            SLT:  exp_res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU: exp_res = (a < b) ? 32'd1 : 32'd0;
            LUI:  exp_res = b;
            BEQ:  exp_cond = (a == b);
            BNE:  exp_cond = (a != b);
            BLT:  exp_cond = ($signed(a) < $signed(b));
            BLTU: exp_cond = (a < b);
            BGE:  exp_cond = ($signed(a) >= $signed(b));
            BGEU: exp_cond = (a >= b);
            JAL: begin
                exp_res    = req_i.pc + 32'd4;
                exp_cond   = 1'b1;
                exp_target = sum;
            end
            JALR: begin
                exp_res    = req_i.pc + 32'd4;
                exp_cond   = 1'b1;
                exp_target = {sum[31:1], 1'b0};
            end
            SB: begin
                exp_be   = 4'b0001 << sum[1:0];
                exp_data = {4{c[7:0]}};
            end
            SH: begin
                exp_be   = sum[1] ? 4'b1100 : 4'b0011;
                exp_data = {2{c[15:0]}};
            end
            SW:      exp_be = 4'b1111;
            default: ;
        endcase
    end

    // Expected flow tag, one step per live taken jump
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            model_tag <= '0;
        end
        else if (live && exp_cond && !stall_i) begin
            model_tag <= model_tag + tag_t'(1);
        end
    end

    ////////////////////////////////////////////////////////////
    // Properties
    ////////////////////////////////////////////////////////////

    a_reset: assert property (@(posedge clk)
        (!reset_n || $past(!reset_n)) |-> (!write_enable_o && op_o == NOP && result_o == '0))
        else begin
            $error("mismatch at %0t: registered outputs not at reset values", $time);
            fail_count++;
        end

    a_kill_jump: assert property (@(posedge clk) disable iff (!reset_n)
        (killed_o == !live) && (jump_o == (exp_cond && live)))
        else begin
            $error("mismatch at %0t: killed_o or jump_o", $time);
            fail_count++;
        end

    a_target: assert property (@(posedge clk) disable iff (!reset_n)
        (is_branch || req_i.op inside {JAL, JALR}) |-> jump_target_o == exp_target)
        else begin
            $error("mismatch at %0t: jump_target_o", $time);
            fail_count++;
        end

    a_mem: assert property (@(posedge clk) disable iff (!reset_n)
        mem_o.address == {sum[31:2], 2'b00} && mem_o.read_en == is_load &&
        mem_o.write_en == exp_be && (!is_store || mem_o.write_data == exp_data))
        else begin
            $error("mismatch at %0t: memory request", $time);
            fail_count++;
        end

    a_registered: assert property (@(posedge clk) disable iff (!reset_n)
        $past(!stall_i && reset_n) |-> op_o == $past(req_i.op) &&
        write_enable_o == $past(live && !is_store && !is_branch) &&
        (!$past(has_res) || result_o == $past(exp_res)))
        else begin
            $error("mismatch at %0t: registered result, write enable or op", $time);
            fail_count++;
        end

    a_stall_hold: assert property (@(posedge clk) disable iff (!reset_n)
        $past(stall_i && reset_n) |-> result_o == $past(result_o) &&
        write_enable_o == $past(write_enable_o) && op_o == $past(op_o))
        else begin
            $error("mismatch at %0t: outputs changed under stall", $time);
            fail_count++;
        end

endmodule

bind execute_top execute_checker u_checker (.*);

`default_nettype wire

// File: bench/tb_execute.sv
`timescale 1ns/1ns
`default_nettype none

module tb_execute
    import exec_pkg::*;
();

    localparam int RUN_CYCLES = 4000;

    logic      clk;
    logic      reset_n;
    logic      stall_i;
    exec_req_t req_i;
    logic      killed_o;
    logic      jump_o;
    word_t     jump_target_o;
    mem_req_t  mem_o;
    word_t     result_o;
    logic      write_enable_o;
    exec_op_e  op_o;

    integer    seed;
    tag_t      model_tag;

    execute_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Checker failures end the run at the next falling edge
    always @(negedge clk) begin
        if (dut0.u_checker.fail_count != 0) begin
            $display("Test failures found");
            $fatal(1, "checker assertion failed");
        end
    end

    initial begin
        repeat (RUN_CYCLES) @(posedge clk);
        $display("Test failures found");
        $fatal(1, "simulation ran past its cycle limit");
    end

    ////////////////////////////////////////////////////////////
    // Request driver
    ////////////////////////////////////////////////////////////

    // Holds the request for some stalled cycles and then lets it through
    task automatic issue(input exec_op_e op, input word_t a, input word_t b, input word_t c,
                         input int stalls, input logic stale);
        exec_req_t r;
        logic      saw_jump;
        int        waited;
        r.op             = op;
        r.pc             = word_t'($random(seed)) & ~32'h3;
        r.first_operand  = a;
        r.second_operand = b;
        r.third_operand  = c;
        r.tag            = stale ? model_tag - tag_t'(1) : model_tag;
        for (int i = 0; i <= stalls; i++) begin
            @(negedge clk);
            req_i    = r;
            stall_i  = (i < stalls);
            #1;
            saw_jump = jump_o & ~stall_i;
            @(posedge clk);
            #1;
            if (saw_jump) begin
                model_tag = model_tag + tag_t'(1);
            end
        end
        waited = 0;
        while (op_o !== op) begin
            if (waited == 4) begin
                $display("Test failures found");
                $fatal(1, "op_o never showed the issued request");
            end
            @(posedge clk);
            waited++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        exec_op_e op;
        word_t    a;
        word_t    b;
        seed      = 32'hf44b1bad;
        model_tag = '0;
        reset_n   = 1'b0;
        stall_i   = 1'b0;
        req_i     = '0;
        // Non-zero request held through reset to expose missing reset values
        req_i.op             = ADD;
        req_i.first_operand  = 32'h1234_5678;
        req_i.second_operand = 32'h0000_4321;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        // Jumps around the whole tag ring with a stale request after each
        for (int i = 0; i < 10; i++) begin
            issue(JAL, 32'h100, 32'h20 * i, '0, 0, 1'b0);
            issue(JAL, 32'h200, 32'h4, '0, 0, 1'b1);
            issue(ADD, 32'h5, 32'h7, '0, i % 3, 1'b0);
        end

        // Random ops with equal operands now and then so BEQ can be taken
        for (int i = 0; i < 600; i++) begin
            op = exec_op_e'($unsigned($random(seed)) % 28);
            a  = $random(seed);
            b  = (($random(seed) & 3) == 0) ? a : $random(seed);
            issue(op, a, b, $random(seed), $unsigned($random(seed)) % 3,
                  ($random(seed) & 3) == 0);
        end

        repeat (2) @(negedge clk);
        if (dut0.u_checker.fail_count != 0) begin
            $display("Test failures found");
            $fatal(1, "checker reported failures");
        end
        else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: hw/exec_alu.sv
`timescale 1ns/1ns
`default_nettype none

module exec_alu
    import exec_pkg::*;
(
    input  exec_op_e op_i,
    input  word_t    pc_i,
    input  word_t    first_operand_i,
    input  word_t    second_operand_i,
    input  word_t    third_operand_i,
    output word_t    sum_o,
    output word_t    alu_result_o,
    output logic     branch_cond_o,
    output word_t    jump_target_o
);

    word_t  sum;
    word_t  sum2_a;
    word_t  sum2_b;
    word_t  sum2;
    word_t  and_res;
    word_t  or_res;
    word_t  xor_res;
    word_t  sll_res;
    word_t  srl_res;
    word_t  sra_res;
    shamt_t shamt;

    logic   equal;
    logic   less_than;
    logic   less_than_u;

    ////////////////////////////////////////////////////////////
    // Adders
    ////////////////////////////////////////////////////////////

    assign sum = first_operand_i + second_operand_i;

    // Second adder is shared by sub, link address and branch target
    always_comb begin
        unique case (op_i)
            SUB:     sum2_a = first_operand_i;
            default: sum2_a = pc_i;
        endcase
    end

    always_comb begin
        unique case (op_i)
            JAL, JALR: sum2_b = LINK_OFFSET;
            SUB:       sum2_b = -second_operand_i;
            default:   sum2_b = third_operand_i;
        endcase
    end

    assign sum2  = sum2_a + sum2_b;
    assign sum_o = sum;

    ////////////////////////////////////////////////////////////
    // Logic, shifts and compares
    ////////////////////////////////////////////////////////////

    assign shamt = second_operand_i[4:0];

    always_comb begin
        and_res     = first_operand_i & second_operand_i;
        or_res      = first_operand_i | second_operand_i;
        xor_res     = first_operand_i ^ second_operand_i;
        sll_res     = first_operand_i << shamt;
        srl_res     = first_operand_i >> shamt;
        sra_res     = word_t'($signed(first_operand_i) >>> shamt);
        equal       = (first_operand_i == second_operand_i);
        less_than   = ($signed(first_operand_i) < $signed(second_operand_i));
        less_than_u = (first_operand_i < second_operand_i);
    end

    // Result select, memory ops fall through to the address sum
    always_comb begin
        unique case (op_i)
            SUB, JAL, JALR: alu_result_o = sum2;
            AND:            alu_result_o = and_res;
            OR:             alu_result_o = or_res;
            XOR:            alu_result_o = xor_res;
            SLL:            alu_result_o = sll_res;
            SRL:            alu_result_o = srl_res;
            SRA:            alu_result_o = sra_res;
            SLT:            alu_result_o = {31'b0, less_than};
            SLTU:           alu_result_o = {31'b0, less_than_u};
            LUI:            alu_result_o = second_operand_i;
            default:        alu_result_o = sum;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Branch decision
    ////////////////////////////////////////////////////////////

    // Ungated here, the kill check lives with the tag
    always_comb begin
        unique case (op_i)
            BEQ:       branch_cond_o = equal;
            BNE:       branch_cond_o = ~equal;
            BLT:       branch_cond_o = less_than;
            BLTU:      branch_cond_o = less_than_u;
            BGE:       branch_cond_o = ~less_than;
            BGEU:      branch_cond_o = ~less_than_u;
            JAL, JALR: branch_cond_o = 1'b1;
            default:   branch_cond_o = 1'b0;
        endcase
    end

    // Conditional branches use pc plus offset from the second adder
    always_comb begin
        unique case (op_i)
            JALR:    jump_target_o = {sum[31:1], 1'b0};
            JAL:     jump_target_o = sum;
            default: jump_target_o = sum2;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/exec_pkg.sv
`default_nettype none

package exec_pkg;

    ////////////////////////////////////////////////////////////
    // Widths with a meaning
    ////////////////////////////////////////////////////////////

    typedef logic [31:0] word_t;
    typedef logic  [2:0] tag_t;
    typedef logic  [3:0] byte_en_t;
    typedef logic  [4:0] shamt_t;

    // Return address step for jal and jalr
    localparam word_t LINK_OFFSET = 32'd4;

    // Low address bits forced to zero on the memory side
    localparam int ALIGN_BITS = 2;

    ////////////////////////////////////////////////////////////
    // Decoded operation
    ////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        NOP,
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        LUI,
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW,
        BEQ,
        BNE,
        BLT,
        BLTU,
        BGE,
        BGEU,
        JAL,
        JALR
    } exec_op_e;

    ////////////////////////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////////////////////////

    // Request from decode, third operand is branch offset or store data
    typedef struct packed {
        exec_op_e op;
        word_t    pc;
        word_t    first_operand;
        word_t    second_operand;
        word_t    third_operand;
        tag_t     tag;
    } exec_req_t;

    typedef struct packed {
        word_t    address;
        logic     read_en;
        byte_en_t write_en;
        word_t    write_data;
    } mem_req_t;

endpackage

`default_nettype wire

// File: hw/execute_top.sv
`timescale 1ns/1ns
`default_nettype none

module execute_top
    import exec_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      stall_i,
    input  exec_req_t req_i,

    output logic      killed_o,
    output logic      jump_o,
    output word_t     jump_target_o,
    output mem_req_t  mem_o,

    output word_t     result_o,
    output logic      write_enable_o,
    output exec_op_e  op_o
);

    word_t sum;
    word_t alu_result;
    logic  branch_cond;

    ////////////////////////////////////////////////////////////
    // Flow tag and kill
    ////////////////////////////////////////////////////////////

    flow_tag u_flow_tag (
        .clk           (clk),
        .reset_n       (reset_n),
        .stall_i       (stall_i),
        .tag_i         (req_i.tag),
        .branch_cond_i (branch_cond),
        .killed_o      (killed_o),
        .jump_o        (jump_o)
    );

    ////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////

    exec_alu u_exec_alu (
        .op_i             (req_i.op),
        .pc_i             (req_i.pc),
        .first_operand_i  (req_i.first_operand),
        .second_operand_i (req_i.second_operand),
        .third_operand_i  (req_i.third_operand),
        .sum_o            (sum),
        .alu_result_o     (alu_result),
        .branch_cond_o    (branch_cond),
        .jump_target_o    (jump_target_o)
    );

    // Load/store request leaves combinationally
    store_align u_store_align (
        .op_i            (req_i.op),
        .sum_i           (sum),
        .third_operand_i (req_i.third_operand),
        .mem_o           (mem_o)
    );

    ////////////////////////////////////////////////////////////
    // Writeback registers
    ////////////////////////////////////////////////////////////

    result_stage u_result_stage (
        .clk            (clk),
        .reset_n        (reset_n),
        .stall_i        (stall_i),
        .op_i           (req_i.op),
        .alu_result_i   (alu_result),
        .killed_i       (killed_o),
        .result_o       (result_o),
        .write_enable_o (write_enable_o),
        .op_o           (op_o)
    );

endmodule

`default_nettype wire

// File: hw/flow_tag.sv
`timescale 1ns/1ns
`default_nettype none

module flow_tag
    import exec_pkg::*;
(
    input  logic clk,
    input  logic reset_n,
    input  logic stall_i,
    input  tag_t tag_i,
    input  logic branch_cond_i,
    output logic killed_o,
    output logic jump_o
);

    tag_t curr_tag;

    ////////////////////////////////////////////////////////////
    // Kill and jump gating
    ////////////////////////////////////////////////////////////

    // Instruction from a flow that was left behind
    assign killed_o = (tag_i != curr_tag);

    // Only a live instruction may redirect fetch
    assign jump_o = branch_cond_i & ~killed_o;

    ////////////////////////////////////////////////////////////
    // Current flow tag
    ////////////////////////////////////////////////////////////

    // Wraps modulo 8, one step per taken jump
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            curr_tag <= '0;
        end
        else if (jump_o && !stall_i) begin
            curr_tag <= curr_tag + tag_t'(1);
        end
    end

endmodule

`default_nettype wire

// File: hw/result_stage.sv
`timescale 1ns/1ns
`default_nettype none

module result_stage
    import exec_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     stall_i,
    input  exec_op_e op_i,
    input  word_t    alu_result_i,
    input  logic     killed_i,
    output word_t    result_o,
    output logic     write_enable_o,
    output exec_op_e op_o
);

    logic no_rd_write;
    logic write_enable;

    ////////////////////////////////////////////////////////////
    // Write enable rule
    ////////////////////////////////////////////////////////////

    // Stores and conditional branches have no destination register
    always_comb begin
        unique case (op_i)
            SB, SH, SW,
            BEQ, BNE,
            BLT, BLTU,
            BGE, BGEU: no_rd_write = 1'b1;
            default:   no_rd_write = 1'b0;
        endcase
    end

    // Killed instructions retire silently
    assign write_enable = ~no_rd_write & ~killed_i;

    ////////////////////////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////////////////////////

    // Frozen while stalled
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            write_enable_o <= 1'b0;
            op_o           <= NOP;
            result_o       <= '0;
        end
        else if (!stall_i) begin
            write_enable_o <= write_enable;
            op_o           <= op_i;
            result_o       <= alu_result_i;
        end
    end

endmodule

`default_nettype wire

// File: hw/store_align.sv
`timescale 1ns/1ns
`default_nettype none

module store_align
    import exec_pkg::*;
(
    input  exec_op_e op_i,
    input  word_t    sum_i,
    input  word_t    third_operand_i,
    output mem_req_t mem_o
);

    ////////////////////////////////////////////////////////////
    // Address and read enable
    ////////////////////////////////////////////////////////////

    // Word aligned, the byte offset goes into the lane enables
    assign mem_o.address = {sum_i[31:ALIGN_BITS], {ALIGN_BITS{1'b0}}};

    assign mem_o.read_en = op_i inside {LB, LBU, LH, LHU, LW};

    ////////////////////////////////////////////////////////////
    // Store lanes
    ////////////////////////////////////////////////////////////

    // Data copied to every lane, enables pick the live ones
    always_comb begin
        unique case (op_i)
            SB:      mem_o.write_data = {4{third_operand_i[7:0]}};
            SH:      mem_o.write_data = {2{third_operand_i[15:0]}};
            default: mem_o.write_data = third_operand_i;
        endcase
    end

    always_comb begin
        unique case (op_i)
            SB: begin
                unique case (sum_i[1:0])
                    2'b11:   mem_o.write_en = 4'b1000;
                    2'b10:   mem_o.write_en = 4'b0100;
                    2'b01:   mem_o.write_en = 4'b0010;
                    default: mem_o.write_en = 4'b0001;
                endcase
            end
            // Upper or lower half by address bit 1
            SH:      mem_o.write_en = sum_i[1] ? 4'b1100 : 4'b0011;
            SW:      mem_o.write_en = 4'b1111;
            default: mem_o.write_en = 4'b0000;
        endcase
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module tb_execute -o sim_execute
./obj_dir/sim_execute +verilator+error+limit+100

// File: src.f
hw/exec_pkg.sv
hw/flow_tag.sv
hw/exec_alu.sv
hw/store_align.sv
hw/result_stage.sv
hw/execute_top.sv
bench/execute_assert.sv
bench/tb_execute.sv
